/* Bender.yml */
package:
  name: mips

sources:
  - source/mips_isa_pkg.sv
  - source/mips_bus_pkg.sv
  - source/mips_ifs.sv
  - source/instr_mem.sv
  - source/controller.sv
  - source/datapath.sv
  - source/bus_master.sv
  - source/mips.sv
  - target: test
    files:
      - verification/tb_mips.sv

/* flist.f */
source/mips_isa_pkg.sv
source/mips_bus_pkg.sv
source/mips_ifs.sv
source/instr_mem.sv
source/controller.sv
source/datapath.sv
source/bus_master.sv
source/mips.sv
verification/tb_mips.sv

/* source/bus_master.sv */
`default_nettype none

module bus_master import mips_isa_pkg::*, mips_bus_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  mem_if.bus_master    mem,
  input  logic         bus_master_ack,
  input  logic         bus_wait,
  input  word_t        bus_data_in,
  output logic         bus_req,
  output logic         bus_write,
  output logic         bus_drive_data,  // Selects bus_word_out onto the bus
  output word_t        bus_word_out
);

  bus_state_e state;
  bus_state_e state_next;
  word_t      rdata_q;

  always_comb begin
    state_next = state;
    case (state)
      BUS_IDLE: if (mem.req) state_next = BUS_REQ;
      BUS_REQ:  if (bus_master_ack) state_next = BUS_ADDR;
      BUS_ADDR: state_next = BUS_DATA;
      BUS_DATA: if (!bus_wait) state_next = BUS_DONE;
      BUS_DONE: state_next = BUS_IDLE;  // req drops for at least this edge
      default:  state_next = BUS_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= BUS_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Load data taken on the last data phase
  always_ff @(posedge clk) begin
    if (state == BUS_DATA && !bus_wait) begin
      rdata_q <= bus_data_in;
    end
  end

  assign bus_req = (state == BUS_REQ) || (state == BUS_ADDR) || (state == BUS_DATA);
  assign bus_write = mem.write && ((state == BUS_ADDR) || (state == BUS_DATA));

  // Address phase, then store data
  assign bus_drive_data = (state == BUS_ADDR) || (state == BUS_DATA && mem.write);
  assign bus_word_out   = (state == BUS_ADDR) ? mem.addr : mem.wdata;

  assign mem.rdata = rdata_q;
  assign mem.done  = (state == BUS_DONE);
  assign mem.stall = mem.req && (state != BUS_DONE);  // Core frozen until done

  // The core keeps its request up until the access is done
  a_req_held: assert property (@(posedge clk) disable iff (reset)
    (state != BUS_IDLE) |-> mem.req)
    else $error("bus_master: mem.req dropped during an access");

endmodule

`default_nettype wire

/* source/controller.sv */
`default_nettype none

module controller import mips_isa_pkg::*; (
  input  word_t              instr,
  ctrl_if.controller         ctrl
);

  opcode_t opcode;
  funct_t  funct;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];

  always_comb begin
    // No-op unless the opcode is recognised
    ctrl.reg_dst    = 1'b0;
    ctrl.alu_src    = 1'b0;
    ctrl.mem_to_reg = 1'b0;
    ctrl.reg_write  = 1'b0;
    ctrl.mem_read   = 1'b0;
    ctrl.mem_write  = 1'b0;
    ctrl.branch     = 1'b0;
    ctrl.jump       = 1'b0;
    ctrl.alu_op     = ALU_ADD;

    case (opcode)
      OP_RTYPE: begin
        ctrl.reg_dst   = 1'b1;  // Destination in rd
        ctrl.reg_write = 1'b1;
        case (funct)
          FN_ADDU: ctrl.alu_op = ALU_ADD;
          FN_SUBU: ctrl.alu_op = ALU_SUB;
          FN_AND:  ctrl.alu_op = ALU_AND;
          FN_OR:   ctrl.alu_op = ALU_OR;
          FN_SLT:  ctrl.alu_op = ALU_SLT;
          default: ctrl.reg_write = 1'b0;  // Unsupported funct
        endcase
      end
      OP_ADDIU: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      OP_LW: begin
        ctrl.alu_src    = 1'b1;  // Base plus offset
        ctrl.mem_to_reg = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.mem_read   = 1'b1;
      end
      OP_SW: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      OP_BEQ: begin
        ctrl.branch = 1'b1;
        ctrl.alu_op = ALU_SUB;  // Equal when the difference is zero
      end
      OP_J: begin
        ctrl.jump = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/datapath.sv */
`default_nettype none

module datapath import mips_isa_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       hold,       // Program load in progress
  input  word_t      instr,
  output word_t      pc,
  ctrl_if.datapath   ctrl,
  mem_if.datapath    mem,
  input  reg_addr_t  debug_ra4,
  output word_t      debug_rd4
);

  word_t     rf [32];
  reg_addr_t rs;
  reg_addr_t rt;
  reg_addr_t rd;
  reg_addr_t rf_wa;
  word_t     rd1;
  word_t     rd2;
  word_t     imm_ext;
  word_t     src_b;
  word_t     alu_result;
  word_t     wb_data;
  word_t     pc_plus4;
  word_t     pc_branch;
  word_t     pc_jump;
  word_t     pc_next;
  logic      mem_op;
  logic      step;       // Instruction completes this cycle
  logic      rf_we;
  logic      zero;

  assign rs      = instr[25:21];
  assign rt      = instr[20:16];
  assign rd      = instr[15:11];
  assign imm_ext = {{16{instr[15]}}, instr[15:0]};

  // Register 0 reads as zero
  assign rd1       = (rs == '0) ? '0 : rf[rs];
  assign rd2       = (rt == '0) ? '0 : rf[rt];
  assign debug_rd4 = (debug_ra4 == '0) ? '0 : rf[debug_ra4];

  assign src_b = ctrl.alu_src ? imm_ext : rd2;

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD: alu_result = rd1 + src_b;
      ALU_SUB: alu_result = rd1 - src_b;
      ALU_AND: alu_result = rd1 & src_b;
      ALU_OR:  alu_result = rd1 | src_b;
      ALU_SLT: alu_result = {31'b0, $signed(rd1) < $signed(src_b)};
      default: alu_result = '0;
    endcase
  end

  assign zero = (alu_result == '0);

  // Memory request to the bus master
  assign mem_op    = ctrl.mem_read | ctrl.mem_write;
  assign mem.req   = mem_op & ~hold;
  assign mem.write = ctrl.mem_write;
  assign mem.addr  = alu_result;
  assign mem.wdata = rd2;

  // Memory instructions finish on done, the rest in one cycle
  assign step = ~hold & (mem_op ? mem.done : ~mem.stall);

  assign pc_plus4  = pc + 32'd4;
  assign pc_branch = pc_plus4 + {imm_ext[29:0], 2'b00};
  assign pc_jump   = {pc_plus4[31:28], instr[25:0], 2'b00};

  always_comb begin
    if (ctrl.jump) pc_next = pc_jump;
    else if (ctrl.branch && zero) pc_next = pc_branch;
    else pc_next = pc_plus4;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (step) begin
      pc <= pc_next;
    end
  end

  assign rf_wa   = ctrl.reg_dst ? rd : rt;
  assign wb_data = ctrl.mem_to_reg ? mem.rdata : alu_result;
  assign rf_we   = step & ctrl.reg_write & (rf_wa != '0);

  always_ff @(posedge clk) begin
    if (rf_we) begin
      rf[rf_wa] <= wb_data;
    end
  end

  // Address must not move under an open bus access
  a_addr_stable: assert property (@(posedge clk) disable iff (reset)
    (mem.req && !mem.done) |=> (mem.req && $stable(mem.addr)))
    else $error("datapath: mem.addr changed while req high");

endmodule

`default_nettype wire

/* source/instr_mem.sv */
`default_nettype none

module instr_mem import mips_isa_pkg::*, mips_bus_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  bus_slave_en,
  input  logic  bus_we,
  input  word_t bus_data_in,
  input  word_t pc,
  output word_t instr
);

  word_t      imem [IMEM_DEPTH];
  imem_addr_t load_addr;
  imem_addr_t rd_addr;
  logic       addr_taken;  // Start word of this load already seen

  always_ff @(posedge clk) begin
    if (reset) begin
      addr_taken <= 1'b0;
      load_addr  <= '0;
    end else if (!bus_slave_en) begin
      addr_taken <= 1'b0;  // Next load starts with a fresh address word
    end else if (bus_we) begin
      if (!addr_taken) begin
        load_addr  <= imem_addr_t'(bus_data_in);
        addr_taken <= 1'b1;
      end else begin
        load_addr <= load_addr + 1'b1;
      end
    end
  end

  // Program words follow the address word
  always_ff @(posedge clk) begin
    if (bus_slave_en && bus_we && addr_taken) begin
      imem[load_addr] <= bus_data_in;
    end
  end

  assign rd_addr = imem_addr_t'(pc >> 2);  // Word index of the PC
  assign instr   = imem[rd_addr];

  // Start address sent by the loading agent must fit the array
  a_load_addr_range: assert property (@(posedge clk) disable iff (reset)
    (bus_slave_en && bus_we && !addr_taken) |-> (bus_data_in < IMEM_DEPTH))
    else $error("instr_mem: load address %0d beyond depth", bus_data_in);

endmodule

`default_nettype wire

/* source/mips.sv */
`default_nettype none

module mips import mips_isa_pkg::*, mips_bus_pkg::*; (
  input  logic      clk,
  input  logic      reset_ext,
  input  bus_ctrl_t bus_ctrl_in,
  input  logic      bus_master_ack,
  input  logic      bus_slave_en,
  input  reg_addr_t debug_ra4,
  output bus_ctrl_t bus_ctrl_out,
  output logic      bus_req,
  output word_t     debug_rd4,
  input  word_t     bus_data_in,
  output word_t     bus_data_out
);

  logic  reset;
  logic  bus_wait;
  logic  bus_we;
  logic  bus_write;
  logic  bus_drive_data;
  word_t bus_word_out;
  word_t pc;
  word_t instr;

  ctrl_if u_ctrl ();
  mem_if  u_mem ();

  always_ff @(posedge clk) begin
    reset <= reset_ext;  // One register stage on the external reset
  end

  assign bus_wait = bus_ctrl_in[CTRL_WAIT];
  assign bus_we   = bus_ctrl_in[CTRL_WRITE];

  always_comb begin
    bus_ctrl_out = '0;  // Wait stays low
    bus_ctrl_out[CTRL_WRITE] = bus_write;
    bus_ctrl_out[CTRL_BURST_HI:CTRL_BURST_LO] = '0;  // Single word
  end

  assign bus_data_out = bus_drive_data ? bus_word_out : '0;

  instr_mem u_instr_mem (.clk(clk), .reset(reset), .bus_slave_en(bus_slave_en),
                         .bus_we(bus_we), .bus_data_in(bus_data_in), .pc(pc),
                         .instr(instr));

  controller u_controller (.instr(instr), .ctrl(u_ctrl.controller));

  datapath u_datapath (.clk(clk), .reset(reset), .hold(bus_slave_en), .instr(instr),
                       .pc(pc), .ctrl(u_ctrl.datapath), .mem(u_mem.datapath),
                       .debug_ra4(debug_ra4), .debug_rd4(debug_rd4));

  bus_master u_bus_master (.clk(clk), .reset(reset), .mem(u_mem.bus_master),
                           .bus_master_ack(bus_master_ack), .bus_wait(bus_wait),
                           .bus_data_in(bus_data_in), .bus_req(bus_req),
                           .bus_write(bus_write), .bus_drive_data(bus_drive_data),
                           .bus_word_out(bus_word_out));

endmodule

`default_nettype wire

/* source/mips_bus_pkg.sv */
`default_nettype none

package mips_bus_pkg;

  localparam int CWIDTH = 8;
  typedef logic [CWIDTH-1:0] bus_ctrl_t;

  // Bit positions in the bus control field
  localparam int CTRL_WAIT     = 0;
  localparam int CTRL_WRITE    = 1;
  localparam int CTRL_BURST_LO = 2;
  localparam int CTRL_BURST_HI = 4;  // Burst length of zero means one word

  localparam int IMEM_DEPTH = 64;
  typedef logic [$clog2(IMEM_DEPTH)-1:0] imem_addr_t;

  typedef enum logic [2:0] {
    BUS_IDLE,
    BUS_REQ,   // Waiting for bus_master_ack
    BUS_ADDR,
    BUS_DATA,  // Repeats while the slave holds wait
    BUS_DONE
  } bus_state_e;

endpackage

`default_nettype wire

/* source/mips_ifs.sv */
`default_nettype none

// Decode results, controller to datapath
interface ctrl_if import mips_isa_pkg::*; ();
  logic    reg_dst;
  logic    alu_src;
  logic    mem_to_reg;
  logic    reg_write;
  logic    mem_read;
  logic    mem_write;
  logic    branch;
  logic    jump;
  alu_op_e alu_op;

  modport controller (output reg_dst, alu_src, mem_to_reg, reg_write, mem_read,
                      mem_write, branch, jump, alu_op);
  modport datapath   (input reg_dst, alu_src, mem_to_reg, reg_write, mem_read,
                      mem_write, branch, jump, alu_op);
endinterface

// Load/store handshake between datapath and bus master
interface mem_if import mips_isa_pkg::*; ();
  logic  req;    // Level held until done
  logic  write;
  word_t addr;
  word_t wdata;
  logic  stall;
  word_t rdata;
  logic  done;   // One-cycle pulse

  modport datapath   (output req, write, addr, wdata, input stall, rdata, done);
  modport bus_master (input req, write, addr, wdata, output stall, rdata, done);
endinterface

`default_nettype wire

/* source/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

  typedef logic [31:0] word_t;     // Data, address and instruction word
  typedef logic [4:0]  reg_addr_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;

  // Primary opcodes of the supported subset
  localparam opcode_t OP_RTYPE = 6'h00;
  localparam opcode_t OP_J     = 6'h02;
  localparam opcode_t OP_BEQ   = 6'h04;
  localparam opcode_t OP_ADDIU = 6'h09;
  localparam opcode_t OP_LW    = 6'h23;
  localparam opcode_t OP_SW    = 6'h2b;

  // R-type funct codes
  localparam funct_t FN_ADDU = 6'h21;
  localparam funct_t FN_SUBU = 6'h23;
  localparam funct_t FN_AND  = 6'h24;
  localparam funct_t FN_OR   = 6'h25;
  localparam funct_t FN_SLT  = 6'h2a;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,  // Also used for the beq compare
    ALU_AND,
    ALU_OR,
    ALU_SLT   // Signed compare
  } alu_op_e;

endpackage

`default_nettype wire

/* verification/mips_input.txt */
# P word: program word from imem word 0 / D addr value: bus memory preload
# S addr value: expected store in order / R reg value: final register (reg decimal)
P 24010005
P 24020003
P ac010200
P 00221821
P 00222023
P 00222824
P 00223025
P 0041382a
P 2408fffe
P 0101482a
P 8c0a0100
P 8c0b0104
P 10210001
P ac0102f0
P 10220001
P ac030204
P 08000012
P ac0102f4
P 014b6021
P ac0c0208
P ac0703fc
P 08000015
D 00000100 12340000
D 00000104 00005678
S 00000200 00000005
S 00000204 00000008
S 00000208 12345678
S 000003fc 00000001
R 1 00000005
R 2 00000003
R 3 00000008
R 4 00000002
R 5 00000001
R 6 00000007
R 7 00000001
R 8 fffffffe
R 9 00000001
R 10 12340000
R 11 00005678
R 12 12345678

/* verification/tb_mips.sv */
`default_nettype none

module tb_mips import mips_isa_pkg::*, mips_bus_pkg::*; ();

  localparam int    SEED      = 18;
  localparam word_t DONE_ADDR = 32'h0000_03fc;  // Last store of the program

  logic      clk;
  logic      reset_ext;
  bus_ctrl_t bus_ctrl_in;
  logic      bus_master_ack;
  logic      bus_slave_en;
  reg_addr_t debug_ra4;
  bus_ctrl_t bus_ctrl_out;
  logic      bus_req;
  word_t     debug_rd4;
  word_t     bus_data_in;
  word_t     bus_data_out;

  word_t  prog_q[$];
  word_t  pre_data_q[$];   // Words preloaded by D lines
  word_t  mem_addr_q[$];   // Bus memory model contents
  word_t  mem_data_q[$];
  word_t  st_addr_q[$];    // Expected stores in order
  word_t  st_data_q[$];
  int     reg_num_q[$];
  word_t  reg_val_q[$];
  integer seed;
  int     cycle_count;
  int     timeout_cycles;
  int     access_count;
  int     store_count;
  int     load_errors;
  int     store_errors;
  int     flow_errors;
  int     pass_count;
  int     fail_count;
  logic   done_seen;
  logic   first_write;
  word_t  first_addr;
  logic   file_ok;

  mips u_mips (.clk(clk), .reset_ext(reset_ext), .bus_ctrl_in(bus_ctrl_in),
               .bus_master_ack(bus_master_ack), .bus_slave_en(bus_slave_en),
               .debug_ra4(debug_ra4), .bus_ctrl_out(bus_ctrl_out), .bus_req(bus_req),
               .debug_rd4(debug_rd4), .bus_data_in(bus_data_in),
               .bus_data_out(bus_data_out));

  always #10 clk = ~clk;

  // Watchdog whose limit is set once the program length is known
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (timeout_cycles > 0 && cycle_count >= timeout_cycles) begin
      if (access_count == 0) begin
        $display("Timeout after %0d cycles: no bus request after program load", cycle_count);
      end else begin
        $display("Timeout after %0d cycles: no store to %h seen", cycle_count, DONE_ADDR);
      end
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // Bus memory model that answers every request of the core
  always @(posedge clk) begin
    if (bus_req === 1'b1) serve_access();
  end

  task automatic mem_write(input word_t addr, input word_t data);
    int idx;
    idx = -1;
    foreach (mem_addr_q[i]) begin
      if (mem_addr_q[i] == addr) idx = i;
    end
    if (idx < 0) begin
      mem_addr_q.push_back(addr);
      mem_data_q.push_back(data);
    end else begin
      mem_data_q[idx] = data;
    end
  endtask

  function automatic logic mem_lookup(input word_t addr, output word_t data);
    logic found;
    found = 1'b0;
    data  = '0;
    foreach (mem_addr_q[i]) begin
      if (mem_addr_q[i] == addr) begin
        data  = mem_data_q[i];
        found = 1'b1;
      end
    end
    return found;
  endfunction

  task automatic read_input_file(output logic ok);
    int               fd;
    int               code;
    int               n;
    int               num;
    logic [7:0]       kind;
    logic [8*160-1:0] line;
    word_t            a;
    word_t            v;
    ok = 1'b0;
    fd = $fopen("verification/mips_input.txt", "r");
    if (fd != 0) begin
      ok   = 1'b1;
      code = $fscanf(fd, " %c", kind);
      while (code == 1) begin
        case (kind)
          "#": n = $fgets(line, fd);  // Column description
          "P": begin
            n = $fscanf(fd, "%h", v);
            prog_q.push_back(v);
          end
          "D": begin
            n = $fscanf(fd, "%h %h", a, v);
            mem_write(a, v);
            pre_data_q.push_back(v);
          end
          "S": begin
            n = $fscanf(fd, "%h %h", a, v);
            st_addr_q.push_back(a);
            st_data_q.push_back(v);
          end
          "R": begin
            n = $fscanf(fd, "%d %h", num, v);
            reg_num_q.push_back(num);
            reg_val_q.push_back(v);
          end
          default: begin
            $display("Input file holds a line of unknown kind %c", kind);
            ok = 1'b0;
          end
        endcase
        code = $fscanf(fd, " %c", kind);
      end
      $fclose(fd);
    end
  endtask

  task automatic check_store(input word_t addr, input word_t data);
    logic listed;
    listed = 1'b0;
    foreach (st_addr_q[i]) begin
      if (st_addr_q[i] == addr) listed = 1'b1;
    end
    if (store_count < st_addr_q.size()) begin
      if (addr !== st_addr_q[store_count]) begin
        $display("Mismatch at time %0t: bus_data_out (address phase) expected %h got %h",
                 $time, st_addr_q[store_count], addr);
        store_errors++;
      end
      if (data !== st_data_q[store_count]) begin
        $display("Mismatch at time %0t: bus_data_out (data phase) expected %h got %h",
                 $time, st_data_q[store_count], data);
        store_errors++;
      end
    end else begin
      $display("Store to %h at time %0t comes after the last expected store", addr, $time);
      flow_errors++;
    end
    if (!listed) begin
      $display("Store to %h at time %0t lies on a path that must be skipped", addr, $time);
      flow_errors++;
    end
    store_count++;
    mem_write(addr, data);
    if (addr == DONE_ADDR) done_seen = 1'b1;
  endtask

  // One access with random ack delay, address phase and data phases with random wait
  task automatic serve_access();
    int    delay;
    int    waits;
    logic  last;
    logic  is_write;
    word_t addr;
    word_t data;
    delay = $unsigned($random(seed)) % 4;
    waits = $unsigned($random(seed)) % 3;
    repeat (delay) @(posedge clk);
    bus_master_ack <= 1'b1;
    @(posedge clk);  // Ack taken here
    bus_master_ack <= 1'b0;
    @(posedge clk);  // End of the address phase
    addr     = bus_data_out;
    is_write = bus_ctrl_out[CTRL_WRITE];
    if (bus_ctrl_out[CTRL_BURST_HI:CTRL_BURST_LO] !== '0) begin
      $display("Mismatch at time %0t: bus_ctrl_out burst expected 0 got %b",
               $time, bus_ctrl_out[CTRL_BURST_HI:CTRL_BURST_LO]);
      store_errors++;
    end
    if (bus_ctrl_out[CTRL_WAIT] !== 1'b0) begin
      $display("Mismatch at time %0t: bus_ctrl_out wait expected 0 got %b",
               $time, bus_ctrl_out[CTRL_WAIT]);
      store_errors++;
    end
    if (access_count == 0) begin
      first_write = is_write;
      first_addr  = addr;
    end
    access_count++;
    if (!is_write) begin
      if (!mem_lookup(addr, data)) begin
        $display("Load from %h at time %0t finds no preloaded word", addr, $time);
        load_errors++;
      end
      bus_data_in <= data;
    end
    last = 1'b0;
    while (!last) begin
      last = (waits == 0);
      bus_ctrl_in[CTRL_WAIT] <= !last;
      @(posedge clk);
      if (waits > 0) waits--;
    end
    if (is_write) begin
      if (bus_ctrl_out[CTRL_WRITE] !== 1'b1) begin
        $display("Mismatch at time %0t: bus_ctrl_out write expected 1 got %b",
                 $time, bus_ctrl_out[CTRL_WRITE]);
        store_errors++;
      end
      check_store(addr, bus_data_out);
    end
    bus_data_in <= '0;
  endtask

  task automatic check_reset_state(output int errors);
    errors = 0;
    repeat (3) begin
      @(posedge clk);
      if (bus_req !== 1'b0) begin
        $display("Mismatch at time %0t: bus_req expected 0 got %b", $time, bus_req);
        errors++;
      end
      if (bus_ctrl_out[CTRL_WRITE] !== 1'b0) begin
        $display("Mismatch at time %0t: bus_ctrl_out write expected 0 got %b",
                 $time, bus_ctrl_out[CTRL_WRITE]);
        errors++;
      end
    end
  endtask

  task automatic load_program();
    bus_ctrl_in[CTRL_WRITE] <= 1'b1;
    bus_data_in             <= '0;  // Start word address
    foreach (prog_q[i]) begin
      @(posedge clk);
      bus_data_in <= prog_q[i];
    end
    @(posedge clk);
    bus_ctrl_in[CTRL_WRITE] <= 1'b0;
    bus_data_in             <= '0;
    bus_slave_en            <= 1'b0;  // Core starts at PC 0
  endtask

  // A register counts as loaded when its value is one of the preloaded words
  task automatic check_registers(input logic want_loaded, output int errors);
    word_t v;
    logic  loaded;
    errors = 0;
    foreach (reg_num_q[i]) begin
      loaded = 1'b0;
      foreach (pre_data_q[j]) begin
        if (pre_data_q[j] == reg_val_q[i]) loaded = 1'b1;
      end
      if (loaded == want_loaded) begin
        debug_ra4 <= reg_addr_t'(reg_num_q[i]);
        @(posedge clk);
        v = debug_rd4;
        if (v !== reg_val_q[i]) begin
          $display("Mismatch at time %0t: debug_rd4 (register %0d) expected %h got %h",
                   $time, reg_num_q[i], reg_val_q[i], v);
          errors++;
        end
      end
    end
  endtask

  task automatic report_test(input string name, input int errors);
    if (errors == 0) begin
      $display("Test %s: passed", name);
      pass_count++;
    end else begin
      $display("Test %s: failed with %0d errors", name, errors);
      fail_count++;
    end
  endtask

  task automatic run_all_tests();
    int errors;
    timeout_cycles = prog_q.size() * 20 + 200;
    repeat (2) @(posedge clk);
    reset_ext <= 1'b0;
    check_reset_state(errors);
    report_test("reset state", errors);
    load_program();
    while (access_count == 0) @(posedge clk);
    errors = 0;
    if (!first_write || first_addr !== st_addr_q[0]) begin
      $display("First bus access went to %h with write %b, expected a store to %h",
               first_addr, first_write, st_addr_q[0]);
      errors++;
    end
    report_test("program load and start", errors);
    while (!done_seen) @(posedge clk);
    repeat (2) @(posedge clk);
    check_registers(1'b0, errors);
    report_test("ALU results", errors);
    check_registers(1'b1, errors);
    report_test("loads under back-pressure", errors + load_errors);
    if (store_count != st_addr_q.size()) begin
      $display("Saw %0d stores, expected %0d", store_count, st_addr_q.size());
      store_errors++;
    end
    report_test("stores", store_errors);
    report_test("control flow", flow_errors);
  endtask

  initial begin
    clk            = 1'b0;
    reset_ext      = 1'b1;
    bus_ctrl_in    = '0;
    bus_master_ack = 1'b0;
    bus_slave_en   = 1'b1;  // Core held until the program is in
    debug_ra4      = '0;
    bus_data_in    = '0;
    seed           = SEED;
    cycle_count    = 0;
    timeout_cycles = 0;
    access_count   = 0;
    store_count    = 0;
    load_errors    = 0;
    store_errors   = 0;
    flow_errors    = 0;
    pass_count     = 0;
    fail_count     = 0;
    done_seen      = 1'b0;
    first_write    = 1'b0;
    first_addr     = '0;
    read_input_file(file_ok);
    if (!file_ok || prog_q.size() == 0 || st_addr_q.size() == 0) begin
      $display("Input file verification/mips_input.txt is missing or incomplete");
      fail_count++;
    end else begin
      run_all_tests();
    end
    $display("Tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
